//--- common/clock_ctrl_pkg.sv
`default_nettype none

package clock_ctrl_pkg;

  //------------------------------------------------------------
  // Widths and phase scale
  //------------------------------------------------------------
  localparam int PHASE_W         = 8;     // VME phase code width
  localparam int STEP_W          = 11;    // Fine step counter width
  localparam int STEPS_PER_CYCLE = 1400;  // Fine steps in one 25 ns cycle
  localparam int PHASE_CODES     = 256;   // Codes per cycle on the VME side

  typedef logic [PHASE_W-1:0] phase_code_t;  // Requested phase, 0-255
  typedef logic [STEP_W-1:0]  step_t;        // Fine position or target, 0-1399

  //------------------------------------------------------------
  // Stepping machine states
  //------------------------------------------------------------
  typedef enum logic [2:0] {
    dps_idle      = 3'd0,  // Locked, no move
    dps_wait_lock = 3'd1,  // PLL in reset or unlocked
    dps_step      = 3'd2,  // Issue one ps_en
    dps_wait_done = 3'd3,  // Wait for port done
    dps_settle    = 3'd4   // One spare cycle per step
  } dps_state_e;

  //------------------------------------------------------------
  // Channel command and status
  //------------------------------------------------------------
  typedef struct packed {
    logic  go;      // Request pending
    step_t target;  // Converted step target
  } dps_cmd_t;

  typedef struct packed {
    logic       busy;      // Move in progress
    dps_state_e state;     // Machine state
    step_t      position;  // Current fine position
  } dps_status_t;

endpackage

`default_nettype wire

//--- logic/reset_gen.sv
`default_nettype none

module reset_gen (
  input  logic clock,               // Main 40 MHz clock
  input  logic rst_n,               // Async reset, active low
  input  logic main_lock,           // Main PLL lock
  input  logic reset_en,            // Refire reset on lock loss
  output logic global_reset,        // Held until first lock
  output logic clock_lock_lost_err  // Lock dropped while running
);

  //------------------------------------------------------------
  // Startup latch and reset register
  //------------------------------------------------------------
  logic startup_done;  // Set on first lock, never clears
  logic first_lock;    // Locked now or locked before

  assign first_lock = main_lock || startup_done;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      startup_done <= 1'b0;
      global_reset <= 1'b1;  // Assert from power-up
    end else begin
      startup_done <= first_lock;                                 // Sticky
      global_reset <= !first_lock || (!main_lock && reset_en);   // Refire on loss
    end
  end

  // Only visible when the refire is disabled, since otherwise
  // global_reset is already high while lock is gone
  assign clock_lock_lost_err = !global_reset && !main_lock;

endmodule

`default_nettype wire

//--- logic/clock_activity_mon.sv
`default_nettype none

module clock_activity_mon #(
  parameter int NUM_AUX = 7  // Monitored aux clock inputs
) (
  input  logic               clock,      // Main 40 MHz clock
  input  logic               rst_n,      // Async reset, active low
  input  logic [NUM_AUX-1:0] aux_clk,    // Unused clock pins
  output logic [NUM_AUX-1:0] aux_active  // 1 while input toggles
);

  //------------------------------------------------------------
  // Dual-edge samples
  //------------------------------------------------------------
  logic [NUM_AUX-1:0] rise_q;  // Sampled on clock rising edge
  logic [NUM_AUX-1:0] fall_q;  // Sampled on clock falling edge

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rise_q <= '0;
    end else begin
      rise_q <= aux_clk;  // First half-cycle sample
    end
  end

  always_ff @(negedge clock or negedge rst_n) begin
    if (!rst_n) begin
      fall_q <= '0;
    end else begin
      fall_q <= aux_clk;  // Second half-cycle sample
    end
  end

  //------------------------------------------------------------
  // Activity flags
  //------------------------------------------------------------
  // A 40 MHz input shifted against clock is caught high on one
  // edge and low on the other, so the pair differs. A stuck pin
  // gives two equal samples.
  assign aux_active = rise_q ^ fall_q;  // Half-cycle difference

endmodule

`default_nettype wire

//--- phaser/phaser_regs.sv
`default_nettype none

module phaser_regs
  import clock_ctrl_pkg::*;
#(
  parameter int NUM_DPS = 5  // Phase-shift channels
) (
  input  logic                       clock,  // Main 40 MHz clock
  input  logic                       rst_n,  // Async reset, active low
  input  logic        [NUM_DPS-1:0]  fire,   // VME set-phase strobe
  input  logic        [NUM_DPS-1:0]  ack,    // Move accepted by machine
  input  phase_code_t [NUM_DPS-1:0]  phase,  // VME phase code per channel
  output dps_cmd_t    [NUM_DPS-1:0]  cmd     // Pending request per channel
);

  //------------------------------------------------------------
  // Code to step conversion
  //------------------------------------------------------------
  // target = (code * 1400 + 128) / 256, rounds to nearest step
  function automatic step_t phase_to_step(input phase_code_t code);
    logic [31:0] scaled;
    scaled = 32'(code) * STEPS_PER_CYCLE + PHASE_CODES / 2;  // Add half LSB
    return step_t'(scaled / PHASE_CODES);                   // Power of 2 divide
  endfunction

  logic  [NUM_DPS-1:0] go_q;      // Request pending flags
  step_t [NUM_DPS-1:0] target_q;  // Held step targets

  //------------------------------------------------------------
  // Pending flags
  //------------------------------------------------------------
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      go_q <= '0;
    end else begin
      for (int i = 0; i < NUM_DPS; i++) begin
        if (fire[i]) begin
          go_q[i] <= 1'b1;  // New request, wins over ack
        end else if (ack[i]) begin
          go_q[i] <= 1'b0;  // Taken by the machine
        end
      end
    end
  end

  //------------------------------------------------------------
  // Targets, newest fire overwrites
  //------------------------------------------------------------
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_DPS; i++) begin
      if (fire[i]) begin
        target_q[i] <= phase_to_step(phase[i]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_DPS; i++) begin
      cmd[i].go     = go_q[i];
      cmd[i].target = target_q[i];
    end
  end

endmodule

`default_nettype wire

//--- phaser/phaser_fsm.sv
`default_nettype none

module phaser_fsm
  import clock_ctrl_pkg::*;
(
  input  logic        clock,      // Main 40 MHz clock
  input  logic        rst_n,      // Async reset, active low
  input  logic        main_lock,  // Main PLL lock
  input  logic        dps_lock,   // This channel's PLL lock
  input  logic        dps_reset,  // VME channel reset
  input  logic        ps_done,    // Port step done
  input  dps_cmd_t    cmd,        // Pending request from regs
  output logic        ack,        // Request taken, one cycle
  output logic        ps_en,      // Port step enable pulse
  output logic        ps_incdec,  // 1 = increment
  output logic        pll_rst,    // Channel PLL reset
  output dps_status_t status      // Busy, state, position
);

  //------------------------------------------------------------
  // Declarations
  //------------------------------------------------------------
  dps_state_e state;      // Current state
  dps_state_e state_nxt;  // Next state
  step_t      position;   // Steps applied since PLL lock
  step_t      target_q;   // Target of the move in progress
  logic       lock_ok;    // PLL running and not held in reset
  logic       at_target;  // Position reached
  logic       step_up;    // Target above position
  logic       busy;       // Move in progress

  assign lock_ok   = dps_lock && !dps_reset;
  assign at_target = (position == target_q);
  assign step_up   = (target_q > position);

  // PLL restarts whenever the main PLL drops or VME asks
  assign pll_rst = !main_lock || dps_reset;

  //------------------------------------------------------------
  // Next-state logic
  //------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      dps_wait_lock: begin
        if (lock_ok) state_nxt = dps_idle;  // PLL ready
      end
      dps_idle: begin
        if (cmd.go) state_nxt = dps_step;   // Start a move
      end
      dps_step: begin
        if (at_target) begin
          state_nxt = dps_idle;             // Move complete
        end else begin
          state_nxt = dps_wait_done;        // ps_en out this cycle
        end
      end
      dps_wait_done: begin
        if (ps_done) state_nxt = dps_settle;
      end
      dps_settle: begin
        state_nxt = dps_step;               // Check for next step
      end
      default: begin
        state_nxt = dps_wait_lock;
      end
    endcase
    if (!lock_ok) state_nxt = dps_wait_lock;  // Abandon any move
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= dps_wait_lock;
    end else begin
      state <= state_nxt;
    end
  end

  //------------------------------------------------------------
  // Position tracking
  //------------------------------------------------------------
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      position <= '0;
    end else if (!lock_ok) begin
      position <= '0;  // Fresh PLL starts at zero shift
    end else if (state == dps_wait_done && ps_done) begin
      if (step_up) begin
        position <= position + 1'b1;
      end else begin
        position <= position - 1'b1;
      end
    end
  end

  // Target held for the whole move
  always_ff @(posedge clock) begin
    if (ack) begin
      target_q <= cmd.target;
    end
  end

  //------------------------------------------------------------
  // Outputs
  //------------------------------------------------------------
  assign ack       = (state == dps_idle) && cmd.go && lock_ok;   // Leaving idle
  assign ps_en     = (state == dps_step) && !at_target && lock_ok;
  assign ps_incdec = (state == dps_step) && step_up;             // Valid with ps_en
  assign busy      = (state == dps_step) || (state == dps_wait_done) ||
                     (state == dps_settle);

  assign status = '{busy: busy, state: state, position: position};

endmodule

`default_nettype wire

//--- logic/clock_ctrl_top.sv
`default_nettype none

module clock_ctrl_top
  import clock_ctrl_pkg::*;
#(
  parameter int NUM_DPS = 5,  // Phase-shift channels
  parameter int NUM_AUX = 7   // Monitored aux clocks
) (
  input  wire                        clock,                // Main 40 MHz clock
  input  wire                        rst_n,                // Async reset, active low
  input  wire                        main_lock,            // Main PLL lock
  input  wire                        reset_en,             // Refire reset on lock loss
  input  wire         [NUM_AUX-1:0]  aux_clk,              // Unused clock pins
  input  wire         [NUM_DPS-1:0]  dps_fire,             // VME set-phase strobes
  input  wire         [NUM_DPS-1:0]  dps_reset,            // VME channel resets
  input  phase_code_t [NUM_DPS-1:0]  dps_phase,            // VME phase codes
  input  wire         [NUM_DPS-1:0]  dps_lock,             // Channel PLL locks
  input  wire         [NUM_DPS-1:0]  ps_done,              // Port step done
  output wire                        global_reset,         // Held until first lock
  output wire                        clock_lock_lost_err,  // Lock lost flag
  output wire         [NUM_AUX-1:0]  aux_active,           // Aux input toggling
  output wire         [NUM_DPS-1:0]  ps_en,                // Port step enables
  output wire         [NUM_DPS-1:0]  ps_incdec,            // Port step directions
  output wire         [NUM_DPS-1:0]  pll_rst,              // Channel PLL resets
  output dps_status_t [NUM_DPS-1:0]  dps_status            // Per-channel status
);

  dps_cmd_t [NUM_DPS-1:0] dps_cmd;  // Regs to machines
  wire      [NUM_DPS-1:0] dps_ack;  // Machines to regs

  //------------------------------------------------------------
  // Global reset and aux clock monitor
  //------------------------------------------------------------
  reset_gen u_reset_gen (
    .clock               (clock),
    .rst_n               (rst_n),
    .main_lock           (main_lock),
    .reset_en            (reset_en),
    .global_reset        (global_reset),
    .clock_lock_lost_err (clock_lock_lost_err)
  );

  clock_activity_mon #(.NUM_AUX(NUM_AUX)) u_activity_mon (
    .clock      (clock),
    .rst_n      (rst_n),
    .aux_clk    (aux_clk),
    .aux_active (aux_active)
  );

  //------------------------------------------------------------
  // Phase request registers
  //------------------------------------------------------------
  phaser_regs #(.NUM_DPS(NUM_DPS)) u_regs (
    .clock (clock),
    .rst_n (rst_n),
    .fire  (dps_fire),
    .ack   (dps_ack),
    .phase (dps_phase),
    .cmd   (dps_cmd)
  );

  //------------------------------------------------------------
  // One stepping machine per channel
  //------------------------------------------------------------
  for (genvar i = 0; i < NUM_DPS; i++) begin : g_dps
    phaser_fsm u_fsm (
      .clock     (clock),
      .rst_n     (rst_n),
      .main_lock (main_lock),
      .dps_lock  (dps_lock[i]),
      .dps_reset (dps_reset[i]),
      .ps_done   (ps_done[i]),
      .cmd       (dps_cmd[i]),
      .ack       (dps_ack[i]),
      .ps_en     (ps_en[i]),
      .ps_incdec (ps_incdec[i]),
      .pll_rst   (pll_rst[i]),
      .status    (dps_status[i])
    );
  end

endmodule

`default_nettype wire

//--- verif/tb_clock_ctrl.sv
`default_nettype none

module tb_clock_ctrl
  import clock_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_DPS     = 5;
  localparam int NUM_AUX     = 7;
  localparam int NUM_MOVES   = 10;                       // Moves over all tests
  localparam int MOVE_CYCLES = 2 * STEPS_PER_CYCLE * 8;  // Bound for one wait
  localparam int WATCHDOG_NS = (NUM_MOVES * STEPS_PER_CYCLE * 8 + 2000) * 40;

  logic                        clock;
  logic                        rst_n;
  logic                        main_lock;
  logic                        reset_en;
  logic        [NUM_AUX-1:0]   aux_clk;
  logic        [NUM_DPS-1:0]   dps_fire;
  logic        [NUM_DPS-1:0]   dps_reset;
  phase_code_t [NUM_DPS-1:0]   dps_phase;
  logic        [NUM_DPS-1:0]   dps_lock;
  logic        [NUM_DPS-1:0]   ps_done;   // Bits owned by the port responders
  logic                        global_reset;
  logic                        clock_lock_lost_err;
  logic        [NUM_AUX-1:0]   aux_active;
  logic        [NUM_DPS-1:0]   ps_en;
  logic        [NUM_DPS-1:0]   ps_incdec;
  logic        [NUM_DPS-1:0]   pll_rst;
  dps_status_t [NUM_DPS-1:0]   dps_status;

  logic [NUM_AUX-1:0] aux_run;        // Aux inputs that toggle
  logic [NUM_AUX-1:0] aux_hold;       // Stuck level of the others
  int                 up_cnt [NUM_DPS];     // Increment steps seen by the port
  int                 dn_cnt [NUM_DPS];     // Decrement steps seen by the port
  int                 pos_model [NUM_DPS];  // Expected channel position
  int                 value_errors;
  int                 other_errors;
  int                 seed_value;

  clock_ctrl_top #(.NUM_DPS(NUM_DPS), .NUM_AUX(NUM_AUX)) dut (
    .clock               (clock),
    .rst_n               (rst_n),
    .main_lock           (main_lock),
    .reset_en            (reset_en),
    .aux_clk             (aux_clk),
    .dps_fire            (dps_fire),
    .dps_reset           (dps_reset),
    .dps_phase           (dps_phase),
    .dps_lock            (dps_lock),
    .ps_done             (ps_done),
    .global_reset        (global_reset),
    .clock_lock_lost_err (clock_lock_lost_err),
    .aux_active          (aux_active),
    .ps_en               (ps_en),
    .ps_incdec           (ps_incdec),
    .pll_rst             (pll_rst),
    .dps_status          (dps_status)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;  // 40 ns period
  end

  // Aux clock at the rate of clock, lagging it by 10 ns
  initial begin
    aux_clk = '0;
    forever begin
      @(posedge clock);
      #10 aux_clk = aux_run | aux_hold;  // High phase
      @(negedge clock);
      #10 aux_clk = aux_hold & ~aux_run; // Low phase
    end
  end

  //------------------------------------------------------------
  // Phase-shift port responders
  //------------------------------------------------------------
  for (genvar c = 0; c < NUM_DPS; c++) begin : g_resp
    initial begin
      int delay;
      ps_done[c] = 1'b0;
      forever begin
        @(negedge clock);
        if (ps_en[c] === 1'b1) begin
          if (ps_incdec[c]) up_cnt[c]++;
          else dn_cnt[c]++;
          delay = 1 + ($urandom % 6);  // 1 to 6 cycles
          repeat (delay) begin
            @(negedge clock);
            if (ps_en[c] === 1'b1) begin
              other_errors++;
              $display("Channel %0d issued ps_en before ps_done", c);
            end
          end
          ps_done[c] = 1'b1;
          @(negedge clock);
          ps_done[c] = 1'b0;
        end
      end
    end
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------
  function automatic int expected_step(input int code);
    real exact;
    exact = code * 1.0 * STEPS_PER_CYCLE / PHASE_CODES;  // Exact fractional step
    return $rtoi(exact + 0.5);                           // Nearest, halves round up
  endfunction

  function automatic logic any_busy();
    for (int c = 0; c < NUM_DPS; c++) begin
      if (dps_status[c].busy) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    value_errors++;
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
  endtask

  task automatic print_summary();
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
  endtask

  task automatic wait_global_reset(input logic value);
    int n;
    n = 0;
    while (global_reset !== value && n < 2) begin
      @(negedge clock);
      n++;
    end
    if (global_reset !== value) begin
      other_errors++;
      $display("global_reset did not go to %0b within two cycles", value);
    end
  endtask

  task automatic pulse_fire(input logic [NUM_DPS-1:0] mask);
    dps_fire = mask;
    @(negedge clock);
    dps_fire = '0;
  endtask

  // Busy rises two cycles after fire, a move ends after three idle samples
  task automatic wait_moves_done(input logic [NUM_DPS-1:0] mask);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    @(negedge clock);
    for (int c = 0; c < NUM_DPS; c++) begin
      if (mask[c] && dps_status[c].busy !== 1'b1) begin
        other_errors++;
        $display("Channel %0d did not start its move after fire", c);
      end
    end
    while (quiet < 3 && cycles < MOVE_CYCLES) begin
      @(negedge clock);
      cycles++;
      quiet = any_busy() ? 0 : quiet + 1;
    end
    if (quiet < 3) begin
      other_errors++;
      $display("Moves did not finish within %0d cycles", MOVE_CYCLES);
    end
  endtask

  task automatic check_channel(input int ch, input int exp_pos, input int exp_up,
                               input int exp_dn);
    if (dps_status[ch].position !== exp_pos)
      report_value($sformatf("dps_status[%0d].position", ch), dps_status[ch].position, exp_pos);
    if (dps_status[ch].busy !== 1'b0)
      report_value($sformatf("dps_status[%0d].busy", ch), dps_status[ch].busy, 0);
    if (dps_status[ch].state !== dps_idle)
      report_value($sformatf("dps_status[%0d].state", ch), dps_status[ch].state, dps_idle);
    if (up_cnt[ch] != exp_up)
      report_value($sformatf("ps_incdec[%0d] up steps", ch), up_cnt[ch], exp_up);
    if (dn_cnt[ch] != exp_dn)
      report_value($sformatf("ps_incdec[%0d] down steps", ch), dn_cnt[ch], exp_dn);
    pos_model[ch] = exp_pos;
  endtask

  task automatic do_move(input int ch, input int code);
    int start;
    int target;
    logic [NUM_DPS-1:0] mask;
    start     = pos_model[ch];
    target    = expected_step(code);
    mask      = '0;
    mask[ch]  = 1'b1;
    up_cnt[ch] = 0;
    dn_cnt[ch] = 0;
    dps_phase[ch] = phase_code_t'(code);
    pulse_fire(mask);
    wait_moves_done(mask);
    check_channel(ch, target, (target > start) ? target - start : 0,
                  (start > target) ? start - target : 0);
  endtask

  //------------------------------------------------------------
  // Tests
  //------------------------------------------------------------
  task automatic check_reset_state();
    if (global_reset !== 1'b1) report_value("global_reset", global_reset, 1);
    if (clock_lock_lost_err !== 1'b0) report_value("clock_lock_lost_err", clock_lock_lost_err, 0);
    if (ps_en !== '0) report_value("ps_en", ps_en, 0);
    if (dut.dps_ack !== '0) report_value("dps_ack", dut.dps_ack, 0);
    for (int c = 0; c < NUM_DPS; c++) begin
      if (dps_status[c].busy !== 1'b0) report_value("dps_status.busy", dps_status[c].busy, 0);
      if (dps_status[c].position !== '0)
        report_value("dps_status.position", dps_status[c].position, 0);
      if (dps_status[c].state !== dps_wait_lock)
        report_value("dps_status.state", dps_status[c].state, dps_wait_lock);
    end
  endtask

  task automatic test_global_reset();
    repeat (3) begin
      @(negedge clock);
      if (global_reset !== 1'b1) report_value("global_reset", global_reset, 1);
    end
    main_lock = 1'b1;
    wait_global_reset(1'b0);           // First lock releases reset
    reset_en  = 1'b1;
    main_lock = 1'b0;
    wait_global_reset(1'b1);           // Refire on lock loss
    main_lock = 1'b1;
    wait_global_reset(1'b0);
    reset_en  = 1'b0;
    main_lock = 1'b0;
    repeat (2) @(negedge clock);
    if (global_reset !== 1'b0) report_value("global_reset", global_reset, 0);
    if (clock_lock_lost_err !== 1'b1) report_value("clock_lock_lost_err", clock_lock_lost_err, 1);
    main_lock = 1'b1;
    @(negedge clock);
    if (clock_lock_lost_err !== 1'b0) report_value("clock_lock_lost_err", clock_lock_lost_err, 0);
  endtask

  task automatic test_clock_activity();
    aux_run  = 7'b1010101;
    aux_hold = 7'b0100000;
    repeat (2) @(negedge clock);       // One full sample pair
    if (aux_active !== aux_run) report_value("aux_active", aux_active, aux_run);
    aux_run  = 7'b0001110;
    aux_hold = 7'b0000001;             // Bit 0 stops high
    repeat (2) @(negedge clock);
    if (aux_active !== aux_run) report_value("aux_active", aux_active, aux_run);
  endtask

  task automatic test_single_moves();
    do_move(0, 0);                     // No step, acked anyway
    do_move(0, 1);
    do_move(0, 128);
    do_move(0, 255);
  endtask

  task automatic test_down_and_supersede();
    int start;
    do_move(0, 64);                    // Down from the top code
    start     = pos_model[0];
    up_cnt[0] = 0;
    dn_cnt[0] = 0;
    dps_phase[0] = phase_code_t'(100);
    pulse_fire(5'b00001);
    repeat (3) @(negedge clock);       // First move under way
    dps_phase[0] = phase_code_t'(200);
    pulse_fire(5'b00001);
    dps_phase[0] = phase_code_t'(30);  // Newest request replaces 200
    pulse_fire(5'b00001);
    wait_moves_done('0);
    check_channel(0, expected_step(30), expected_step(100) - start,
                  expected_step(100) - expected_step(30));
  endtask

  task automatic test_channel_reset();
    dps_reset[0] = 1'b1;
    @(negedge clock);
    if (pll_rst[0] !== 1'b1) report_value("pll_rst[0]", pll_rst[0], 1);
    if (dps_status[0].state !== dps_wait_lock)
      report_value("dps_status[0].state", dps_status[0].state, dps_wait_lock);
    if (dps_status[0].position !== '0)
      report_value("dps_status[0].position", dps_status[0].position, 0);
    dps_reset[0] = 1'b0;
    pos_model[0] = 0;
    @(negedge clock);
    do_move(0, 50);
    dps_lock[0] = 1'b0;                // Channel PLL unlocks
    @(negedge clock);
    if (pll_rst[0] !== 1'b0) report_value("pll_rst[0]", pll_rst[0], 0);
    if (dps_status[0].state !== dps_wait_lock)
      report_value("dps_status[0].state", dps_status[0].state, dps_wait_lock);
    if (dps_status[0].position !== '0)
      report_value("dps_status[0].position", dps_status[0].position, 0);
    dps_lock[0]  = 1'b1;
    pos_model[0] = 0;
    @(negedge clock);
    do_move(0, 20);
  endtask

  task automatic test_parallel();
    int codes [NUM_DPS];
    int start [NUM_DPS];
    int target;
    codes = '{17, 90, 160, 222, 3};
    for (int c = 0; c < NUM_DPS; c++) begin
      start[c]     = pos_model[c];
      up_cnt[c]    = 0;
      dn_cnt[c]    = 0;
      dps_phase[c] = phase_code_t'(codes[c]);
    end
    pulse_fire('1);
    wait_moves_done('1);
    for (int c = 0; c < NUM_DPS; c++) begin
      target = expected_step(codes[c]);
      check_channel(c, target, (target > start[c]) ? target - start[c] : 0,
                    (start[c] > target) ? start[c] - target : 0);
    end
  endtask

  //------------------------------------------------------------
  // Sequence, watchdog and summary
  //------------------------------------------------------------
  initial begin
    seed_value = $urandom(32'hc592_4908);
    rst_n      = 1'b0;
    main_lock  = 1'b0;
    reset_en   = 1'b0;
    aux_run    = '0;
    aux_hold   = '0;
    dps_fire   = '0;
    dps_reset  = '0;
    dps_phase  = '0;
    dps_lock   = '0;               // Keeps every machine in wait_lock
    repeat (5) @(negedge clock);
    check_reset_state();
    rst_n = 1'b1;
    test_global_reset();
    test_clock_activity();
    dps_lock = '1;
    repeat (2) @(negedge clock);   // wait_lock to idle takes one cycle
    for (int c = 0; c < NUM_DPS; c++) begin
      if (dps_status[c].state !== dps_idle)
        report_value("dps_status.state", dps_status[c].state, dps_idle);
    end
    test_single_moves();
    test_down_and_supersede();
    test_channel_reset();
    test_parallel();
    print_summary();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    print_summary();
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
common/clock_ctrl_pkg.sv
logic/reset_gen.sv
logic/clock_activity_mon.sv
phaser/phaser_regs.sv
phaser/phaser_fsm.sv
logic/clock_ctrl_top.sv
verif/tb_clock_ctrl.sv
